// File: Makefile
# Verilator build and run for the stream-reduction accelerator testbench
# Override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= accel_tb
FILELIST  ?= accel_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: accel_top.f
logic/accel_pkg.sv
logic/cu_stream_if.sv
logic/cu_result_if.sv
logic/job_dispatcher.sv
logic/compute_unit.sv
logic/result_collector.sv
logic/soft_reset_control.sv
logic/done_control.sv
logic/accel_top.sv
bench/accel_checker.sv
bench/accel_tb.sv

// File: bench/accel_checker.sv
// Checker for the stream-reduction accelerator testbench
// Watches the DUT ports only and scores one result per job, in job order
// Expected values come from the words handed over through add_word and close_job
// Assumes result_ack is a single-cycle pulse
`timescale 1ns/1ns

module accel_checker (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled_in,
	input  logic        in_valid,
	input  logic        in_ready,
	input  logic        in_last,
	input  logic        result_ack,
	input  logic        result_valid,
	input  logic [63:0] result_word,
	input  logic [31:0] stat_words,
	input  logic [7:0]  stat_lanes,
	output int          tests_done,
	output int          tests_failed,
	output int          error_count
);
	import accel_pkg::*;

	// Shortest in_ready low time after the last word: finish, done, soft reset
	localparam int MIN_BLOCK_CYCLES = SOFT_RESET_CYCLES + 2;

	// Outstanding jobs, oldest first
	logic [31:0] exp_sum_q    [$];
	logic [31:0] exp_parity_q [$];
	int          exp_count_q  [$];

	// Job being handed over
	logic [31:0] acc_sum;
	logic [31:0] acc_parity;
	int          acc_count;

	logic        valid_q;
	logic        ack_seen;
	logic        en_q1;
	logic        en_q2;
	logic        after_last;
	logic        test_bad;
	int          block_run;
	int          exp_lanes;
	logic [63:0] held_word;
	logic [31:0] held_words;
	logic [7:0]  held_lanes;

	////////////////////////////////////////
	// Expected values
	////////////////////////////////////////

	task automatic add_word(input logic [31:0] w);
		acc_sum    = acc_sum + w;
		acc_parity = acc_parity ^ w;
		acc_count  = acc_count + 1;
	endtask

	task automatic close_job();
		exp_sum_q.push_back(acc_sum);
		exp_parity_q.push_back(acc_parity);
		exp_count_q.push_back(acc_count);
		acc_sum    = '0;
		acc_parity = '0;
		acc_count  = 0;
	endtask

	task automatic value_error(input string what, input logic [63:0] got,
			input logic [63:0] want);
		$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
		error_count = error_count + 1;
		test_bad    = 1'b1;
	endtask

	task automatic handshake_error(input string what);
		$display("Handshake error at %0t ns: %s", $time, what);
		error_count = error_count + 1;
		test_bad    = 1'b1;
	endtask

	////////////////////////////////////////
	// Port monitor
	////////////////////////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			tests_done   = 0;
			tests_failed = 0;
			error_count  = 0;
			acc_sum      = '0;
			acc_parity   = '0;
			acc_count    = 0;
			valid_q      = 1'b0;
			ack_seen     = 1'b0;
			en_q1        = 1'b0;
			en_q2        = 1'b0;
			after_last   = 1'b0;
			test_bad     = 1'b0;
			block_run    = 0;
		end else begin
			// Host held off after the last word
			if (in_valid && in_ready && in_last) begin
				after_last = 1'b1;
				block_run  = 0;
			end else if (after_last) begin
				if (!in_ready) begin
					block_run = block_run + 1;
				end else begin
					if (block_run < MIN_BLOCK_CYCLES)
						handshake_error("in_ready returned before the lanes were cleared");
					after_last = 1'b0;
				end
			end

			// New result
			if (result_valid && !valid_q) begin
				// enabled_in is registered once in the DUT
				if (!en_q2)
					handshake_error("result_valid rose while enabled_in was low");
				if (exp_sum_q.size() == 0) begin
					handshake_error("result_valid rose with no job outstanding");
				end else begin
					exp_lanes = (exp_count_q[0] < N_CU) ? exp_count_q[0] : N_CU;
					if (result_word !== {exp_sum_q[0], exp_parity_q[0]})
						value_error("result_word", result_word,
							{exp_sum_q[0], exp_parity_q[0]});
					if (stat_words !== 32'(exp_count_q[0]))
						value_error("stat_words", 64'(stat_words), 64'(exp_count_q[0]));
					if (stat_lanes !== 8'(exp_lanes))
						value_error("stat_lanes", 64'(stat_lanes), 64'(exp_lanes));
					void'(exp_sum_q.pop_front());
					void'(exp_parity_q.pop_front());
					void'(exp_count_q.pop_front());
				end
				held_word  = result_word;
				held_words = stat_words;
				held_lanes = stat_lanes;
			end else if (result_valid && valid_q) begin
				// Must not move while presented
				if (result_word !== held_word)
					value_error("held result_word", result_word, held_word);
				if (stat_words !== held_words || stat_lanes !== held_lanes)
					value_error("held statistics", {24'd0, stat_words, stat_lanes},
						{24'd0, held_words, held_lanes});
			end

			if (ack_seen && result_valid)
				handshake_error("result_valid still high the cycle after result_ack");

			// Falling result_valid closes the test
			if (!result_valid && valid_q) begin
				// Only an accepted ack may end the presentation
				if (!ack_seen)
					handshake_error("result_valid dropped before result_ack");
				$display("Test %0d %s, %0d words", tests_done, test_bad ? "FAIL" : "ok",
					held_words);
				tests_done = tests_done + 1;
				if (test_bad)
					tests_failed = tests_failed + 1;
				test_bad = 1'b0;
			end

			ack_seen = result_valid && result_ack && en_q1;
			valid_q  = result_valid;
			en_q2    = en_q1;
			en_q1    = enabled_in;
		end
	end

endmodule

// File: bench/accel_tb.sv
// Testbench for the stream-reduction accelerator
// Jobs come from a table; data words come from a 32-bit Fibonacci LFSR
// Inputs change on the falling edge, the checker samples on the rising edge
// A job may reuse the previous job's words to show that nothing carries over
`timescale 1ns/1ns

module accel_tb;

	localparam int N_JOBS       = 8;
	localparam int MAX_WORDS    = 16;
	localparam int RESET_CYCLES = 10;
	// Watchdog allowance per job on top of its own length
	localparam int JOB_MARGIN   = 60;

	////////////////////////////////////////
	// Job table
	////////////////////////////////////////

	// Words per job
	localparam int JOB_WORDS     [N_JOBS] = '{1, 13, 7, 5, 6, 6, 9, 3};
	// Keep in_valid high past in_last
	localparam int JOB_HOLD      [N_JOBS] = '{0, 0, 1, 0, 0, 0, 0, 1};
	// Send the previous job's words again
	localparam int JOB_REUSE     [N_JOBS] = '{0, 0, 0, 0, 0, 1, 0, 0};
	// Cycles between result_valid and result_ack
	localparam int JOB_ACK_DELAY [N_JOBS] = '{0, 1, 2, 12, 0, 0, 1, 3};
	// Cycles enabled_in stays low after the last word
	localparam int JOB_GAP       [N_JOBS] = '{0, 0, 0, 0, 0, 0, 15, 0};

	logic        clock;
	logic        rstn;
	logic        enabled_in;
	logic        in_valid;
	logic [31:0] in_data;
	logic        in_last;
	logic        result_ack;
	logic        in_ready;
	logic        result_valid;
	logic [63:0] result_word;
	logic [31:0] stat_words;
	logic [7:0]  stat_lanes;
	int          tests_done;
	int          tests_failed;
	int          error_count;

	logic [31:0] lfsr_state = 32'hff9f031f;
	logic [31:0] job_words [MAX_WORDS];

	accel_top dut_i (
		.clock        (clock),
		.rstn         (rstn),
		.enabled_in   (enabled_in),
		.in_valid     (in_valid),
		.in_data      (in_data),
		.in_last      (in_last),
		.result_ack   (result_ack),
		.in_ready     (in_ready),
		.result_valid (result_valid),
		.result_word  (result_word),
		.stat_words   (stat_words),
		.stat_lanes   (stat_lanes)
	);

	accel_checker checker_i (
		.clock        (clock),
		.rstn         (rstn),
		.enabled_in   (enabled_in),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_last      (in_last),
		.result_ack   (result_ack),
		.result_valid (result_valid),
		.result_word  (result_word),
		.stat_words   (stat_words),
		.stat_lanes   (stat_lanes),
		.tests_done   (tests_done),
		.tests_failed (tests_failed),
		.error_count  (error_count)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per data bit
	task automatic draw_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w          = {w[30:0], lfsr_state[31]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_word(input logic [31:0] w, input logic last);
		in_valid = 1'b1;
		in_data  = w;
		in_last  = last;
		while (!in_ready)
			@(negedge clock);
		@(negedge clock);
	endtask

	task automatic run_job(input int j);
		if (JOB_REUSE[j] == 0)
			for (int k = 0; k < JOB_WORDS[j]; k++)
				draw_word(job_words[k]);
		for (int k = 0; k < JOB_WORDS[j]; k++)
			checker_i.add_word(job_words[k]);
		checker_i.close_job();

		for (int k = 0; k < JOB_WORDS[j]; k++) begin
			// Done FSM frozen across the end of the job
			if (JOB_GAP[j] > 0 && k == JOB_WORDS[j] - 1)
				enabled_in = 1'b0;
			send_word(job_words[k], k == JOB_WORDS[j] - 1);
		end
		in_last = 1'b0;
		if (JOB_HOLD[j] != 0) begin
			// Keep offering a filler word while the DUT holds the host off
			in_data = 32'hffff_ffff;
			while (!in_ready)
				@(negedge clock);
		end
		in_valid = 1'b0;
		if (JOB_GAP[j] > 0) begin
			repeat (JOB_GAP[j]) @(negedge clock);
			enabled_in = 1'b1;
		end

		while (!result_valid)
			@(negedge clock);
		repeat (JOB_ACK_DELAY[j]) @(negedge clock);
		result_ack = 1'b1;
		@(negedge clock);
		result_ack = 1'b0;
		while (result_valid)
			@(negedge clock);
	endtask

	////////////////////////////////////////
	// Clock, stimulus and watchdog
	////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin : stimulus
		rstn       = 1'b0;
		enabled_in = 1'b1;
		in_valid   = 1'b0;
		in_data    = '0;
		in_last    = 1'b0;
		result_ack = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		for (int j = 0; j < N_JOBS; j++)
			run_job(j);
		repeat (4) @(negedge clock);
		$display("Tests run %0d of %0d, failed %0d, check errors %0d",
			tests_done, N_JOBS, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0 && tests_done == N_JOBS)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin : watchdog
		int budget;
		budget = RESET_CYCLES + JOB_MARGIN;
		for (int j = 0; j < N_JOBS; j++)
			budget = budget + JOB_WORDS[j] + JOB_ACK_DELAY[j] + JOB_GAP[j] + JOB_MARGIN;
		repeat (budget) @(posedge clock);
		$display("Timeout: the jobs did not complete within %0d clock cycles", budget);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: logic/accel_pkg.sv
// Shared sizes and types for the stream-reduction accelerator
// N_CU may range from 2 to 16; lanes_used is only 8 bits wide
// The return word is one 64-bit union, so sum and parity share no other storage

package accel_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////

	// Compute unit count
	localparam int N_CU = 4;
	// Lane index width
	localparam int LANE_BITS = $clog2(N_CU);
	// Soft reset low time in cycles
	localparam int SOFT_RESET_CYCLES = 4;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// Done FSM states
	typedef enum logic [2:0] {
		DONE_RESET,
		DONE_IDLE,
		DONE_RESET_REQ,
		DONE_RESET_PENDING,
		DONE_MMIO_REQ
	} done_state;

	// Per-job response statistics, 40 bits
	typedef struct packed {
		logic [31:0] words_total;
		logic [7:0]  lanes_used;
	} response_stats_t;

	// Return word, written by field and read raw
	typedef union packed {
		logic [63:0] raw;
		struct packed {
			// Sum of all words mod 2^32
			logic [31:0] sum;
			// XOR of all words
			logic [31:0] parity;
		} fields;
	} cu_return_u;

endpackage

// File: logic/accel_top.sv
// Stream-reduction accelerator top level
// One job between the first word and result_ack; no jobs overlap
// in_ready drops after in_last until the lanes are cleared by soft reset
// result_word, stat_words and stat_lanes are stable while result_valid is high
`timescale 1ns/1ns

module accel_top (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled_in,
	input  logic        in_valid,
	input  logic [31:0] in_data,
	input  logic        in_last,
	input  logic        result_ack,
	output logic        in_ready,
	output logic        result_valid,
	output logic [63:0] result_word,
	output logic [31:0] stat_words,
	output logic [7:0]  stat_lanes
);
	import accel_pkg::*;

	// Lane links
	cu_stream_if stream_if [N_CU] ();
	cu_result_if result_if [N_CU] ();

	logic [31:0]     words_total;
	logic            all_done;
	logic            reset_done;
	logic            soft_rstn;
	cu_return_u      cu_return;
	response_stats_t collected_stats;
	response_stats_t report_stats;

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	job_dispatcher dispatcher_i (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_last     (in_last),
		.in_ready    (in_ready),
		.lanes       (stream_if),
		.words_total (words_total)
	);

	for (genvar i = 0; i < N_CU; i++) begin : g_cu
		compute_unit cu_i (
			.clock     (clock),
			.rstn      (rstn),
			.soft_rstn (soft_rstn),
			.stream    (stream_if[i]),
			.result    (result_if[i])
		);
	end

	result_collector collector_i (
		.lanes               (result_if),
		.words_total         (words_total),
		.all_done            (all_done),
		.cu_return           (cu_return),
		.response_statistics (collected_stats)
	);

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	done_control done_i (
		.clock                      (clock),
		.rstn                       (rstn),
		.soft_rstn                  (soft_rstn),
		.enabled_in                 (enabled_in),
		.cu_return                  (cu_return),
		.response_statistics        (collected_stats),
		.cu_done                    (all_done),
		.cu_return_done_ack         (result_ack),
		.reset_done                 (reset_done),
		.cu_return_done_valid       (result_valid),
		.cu_return_done             (result_word),
		.report_response_statistics (report_stats)
	);

	soft_reset_control soft_reset_i (
		.clock      (clock),
		.rstn       (rstn),
		.reset_done (reset_done),
		.soft_rstn  (soft_rstn)
	);

	// Statistics out as plain ports
	assign stat_words = report_stats.words_total;
	assign stat_lanes = report_stats.lanes_used;

endmodule

// File: logic/compute_unit.sv
// One reduction lane: running sum, running XOR and word count
// soft_rstn low clears every register and holds ready low
// After finish the lane stays done and refuses words until soft reset
`timescale 1ns/1ns

module compute_unit (
	input  logic     clock,
	input  logic     rstn,
	input  logic     soft_rstn,
	cu_stream_if.unit stream,
	cu_result_if.unit result
);

	logic        done_q;
	logic [31:0] sum_q;
	logic [31:0] parity_q;
	logic [31:0] count_q;
	logic        take;

	// Busy in soft reset or once finished
	assign stream.ready = soft_rstn && !done_q;
	assign take         = stream.valid && stream.ready;

	////////////////////////////////////////
	// Accumulators
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			done_q   <= 1'b0;
			sum_q    <= '0;
			parity_q <= '0;
			count_q  <= '0;
		end else if (!soft_rstn) begin
			// Soft reset wipes the job
			done_q   <= 1'b0;
			sum_q    <= '0;
			parity_q <= '0;
			count_q  <= '0;
		end else begin
			if (take) begin
				sum_q    <= sum_q + stream.data;
				parity_q <= parity_q ^ stream.data;
				count_q  <= count_q + 32'd1;
			end
			// Done one cycle after finish
			if (stream.finish)
				done_q <= 1'b1;
		end
	end

	// Result view
	assign result.done   = done_q;
	assign result.sum    = sum_q;
	assign result.parity = parity_q;
	assign result.count  = count_q;

endmodule

// File: logic/cu_result_if.sv
// Result of one compute unit toward the collector
// done stays high from the cycle after finish until soft reset
// The collector only reads these signals
`timescale 1ns/1ns

interface cu_result_if;

	// Lane finished its share of the job
	logic        done;
	// Running sum mod 2^32
	logic [31:0] sum;
	// Running XOR
	logic [31:0] parity;
	// Words taken by this lane
	logic [31:0] count;

	modport unit (
		output done,
		output sum,
		output parity,
		output count
	);

	modport collector (
		input done,
		input sum,
		input parity,
		input count
	);

endinterface

// File: logic/cu_stream_if.sv
// Word stream from the dispatcher to one compute unit
// A word moves when valid and ready are both high
// finish is a one-cycle end-of-job pulse, sent after the last word
`timescale 1ns/1ns

interface cu_stream_if;

	// Word qualifier from the dispatcher
	logic        valid;
	// Low while the unit is in soft reset or finished
	logic        ready;
	logic [31:0] data;
	// End of job mark
	logic        finish;

	modport dispatcher (
		output valid,
		output data,
		output finish,
		input  ready
	);

	modport unit (
		input  valid,
		input  data,
		input  finish,
		output ready
	);

endinterface

// File: logic/done_control.sv
// Done FSM: latch results, request a soft reset, wait for it, present results
// State only advances while enabled_in (registered once) is high
// Result outputs are valid only while cu_return_done_valid is high
// Payload registers clear in DONE_RESET, not through rstn
`timescale 1ns/1ns

module done_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       soft_rstn,
	input  logic                       enabled_in,
	input  accel_pkg::cu_return_u      cu_return,
	input  accel_pkg::response_stats_t response_statistics,
	input  logic                       cu_done,
	input  logic                       cu_return_done_ack,
	output logic                       reset_done,
	output logic                       cu_return_done_valid,
	output logic [63:0]                cu_return_done,
	output accel_pkg::response_stats_t report_response_statistics
);
	import accel_pkg::*;

	done_state       current_state;
	done_state       next_state;
	done_state       state_d;
	logic            enabled;
	logic            sync_meta;
	logic            sync_q;
	logic            done_soft_rstn;
	logic [63:0]     return_latched;
	response_stats_t stats_latched;

	////////////////////////////////////////
	// Soft reset release detect
	////////////////////////////////////////

	// Two flops, then a sticky edge flag
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sync_meta      <= 1'b1;
			sync_q         <= 1'b1;
			done_soft_rstn <= 1'b0;
		end else begin
			sync_meta <= soft_rstn;
			sync_q    <= sync_meta;
			// Kept until the FSM is back in idle, so disabled cycles cannot lose it
			done_soft_rstn <= (!sync_q && sync_meta)
				|| (done_soft_rstn && current_state != DONE_IDLE);
		end
	end

	////////////////////////////////////////
	// Enable and state register
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	// Hold the state while disabled
	assign state_d = enabled ? next_state : current_state;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			current_state        <= DONE_RESET;
			reset_done           <= 1'b1;
			cu_return_done_valid <= 1'b0;
		end else begin
			current_state        <= state_d;
			// One cycle low after DONE_RESET_REQ
			reset_done           <= (current_state != DONE_RESET_REQ);
			// Tracks DONE_MMIO_REQ, drops the cycle after ack
			cu_return_done_valid <= (state_d == DONE_MMIO_REQ);
		end
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			DONE_RESET:
				next_state = DONE_IDLE;
			DONE_IDLE:
				if (cu_done)
					next_state = DONE_RESET_REQ;
			DONE_RESET_REQ:
				next_state = DONE_RESET_PENDING;
			DONE_RESET_PENDING:
				if (done_soft_rstn)
					next_state = DONE_MMIO_REQ;
			DONE_MMIO_REQ:
				if (cu_return_done_ack)
					next_state = DONE_IDLE;
			default:
				next_state = DONE_RESET;
		endcase
	end

	////////////////////////////////////////
	// Result latching
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		case (current_state)
			DONE_RESET: begin
				return_latched             <= '0;
				stats_latched              <= '0;
				cu_return_done             <= '0;
				report_response_statistics <= '0;
			end
			DONE_IDLE: begin
				// Track lanes until they are all done
				return_latched             <= cu_return.raw;
				stats_latched              <= response_statistics;
				cu_return_done             <= '0;
				report_response_statistics <= '0;
			end
			DONE_RESET_PENDING, DONE_MMIO_REQ: begin
				// Loaded ahead of valid so data is settled when it rises
				cu_return_done             <= return_latched;
				report_response_statistics <= stats_latched;
			end
			default: begin
				cu_return_done             <= cu_return_done;
				report_response_statistics <= report_response_statistics;
			end
		endcase
	end

endmodule

// File: logic/job_dispatcher.sv
// Round-robin word dispatch to the compute units
// One job at a time; every job starts again at lane 0
// in_ready rises only once all lanes have gone busy and come back ready
// words_total restarts at the first word of the next job
`timescale 1ns/1ns

module job_dispatcher (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   in_valid,
	input  logic [31:0]            in_data,
	input  logic                   in_last,
	output logic                   in_ready,
	cu_stream_if.dispatcher        lanes [accel_pkg::N_CU],
	output logic [31:0]            words_total
);
	import accel_pkg::*;

	logic [LANE_BITS-1:0] lane_ptr;
	logic [N_CU-1:0]      lane_ready;
	logic                 all_ready;
	logic                 accept;
	logic                 last_accept;
	logic                 armed;
	logic                 blocked;
	logic                 busy_seen;
	logic                 job_open;
	logic                 finish_q;

	////////////////////////////////////////
	// Lane fan-out
	////////////////////////////////////////

	for (genvar i = 0; i < N_CU; i++) begin : g_lane
		// Only the addressed lane sees the word
		assign lanes[i].valid  = accept && (lane_ptr == LANE_BITS'(i));
		assign lanes[i].data   = in_data;
		assign lanes[i].finish = finish_q;
		assign lane_ready[i]   = lanes[i].ready;
	end

	assign all_ready   = &lane_ready;
	// Held off right after reset, after the last word, and while any lane is busy
	assign in_ready    = armed && !blocked && all_ready;
	assign accept      = in_valid && in_ready;
	assign last_accept = accept && in_last;

	////////////////////////////////////////
	// Pointer, counters and job blocking
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			armed       <= 1'b0;
			blocked     <= 1'b0;
			busy_seen   <= 1'b0;
			job_open    <= 1'b0;
			finish_q    <= 1'b0;
			lane_ptr    <= '0;
			words_total <= '0;
		end else begin
			armed    <= 1'b1;
			// finish follows the last word by one cycle
			finish_q <= last_accept;

			if (accept) begin
				// First word of a job restarts the count
				words_total <= job_open ? words_total + 32'd1 : 32'd1;
				job_open    <= !in_last;
				if (in_last || lane_ptr == LANE_BITS'(N_CU - 1))
					lane_ptr <= '0;
				else
					lane_ptr <= lane_ptr + 1'b1;
			end

			// Block until lanes drop ready, then come back after soft reset
			if (last_accept)
				blocked <= 1'b1;
			else if (blocked && busy_seen && all_ready)
				blocked <= 1'b0;

			if (blocked && !all_ready)
				busy_seen <= 1'b1;
			else if (!blocked)
				busy_seen <= 1'b0;
		end
	end

endmodule

// File: logic/result_collector.sv
// Merges the lane results into the return word and statistics
// Purely combinational; values are final only while all_done is high
// lanes_used counts lanes with a non-zero word count
`timescale 1ns/1ns

module result_collector (
	cu_result_if.collector               lanes [accel_pkg::N_CU],
	input  logic [31:0]                  words_total,
	output logic                         all_done,
	output accel_pkg::cu_return_u        cu_return,
	output accel_pkg::response_stats_t   response_statistics
);
	import accel_pkg::*;

	logic [N_CU-1:0] lane_done;
	logic [N_CU-1:0] lane_active;
	logic [31:0]     lane_sum    [N_CU];
	logic [31:0]     lane_parity [N_CU];

	// Flatten the interface array
	for (genvar i = 0; i < N_CU; i++) begin : g_lane
		assign lane_done[i]   = lanes[i].done;
		assign lane_active[i] = |lanes[i].count;
		assign lane_sum[i]    = lanes[i].sum;
		assign lane_parity[i] = lanes[i].parity;
	end

	// Every lane must have finished
	assign all_done = &lane_done;

	////////////////////////////////////////
	// Reduction
	////////////////////////////////////////

	always_comb begin
		cu_return.fields.sum                = '0;
		cu_return.fields.parity             = '0;
		response_statistics.lanes_used      = '0;
		// Word count comes from the dispatcher
		response_statistics.words_total     = words_total;
		for (int i = 0; i < N_CU; i++) begin
			cu_return.fields.sum           = cu_return.fields.sum + lane_sum[i];
			cu_return.fields.parity        = cu_return.fields.parity ^ lane_parity[i];
			response_statistics.lanes_used = response_statistics.lanes_used
				+ 8'(lane_active[i]);
		end
	end

endmodule

// File: logic/soft_reset_control.sv
// Turns a falling reset_done into a timed soft reset
// soft_rstn is low for exactly SOFT_RESET_CYCLES cycles
// A new request while the counter runs restarts it
`timescale 1ns/1ns

module soft_reset_control (
	input  logic clock,
	input  logic rstn,
	input  logic reset_done,
	output logic soft_rstn
);
	import accel_pkg::*;

	logic [$clog2(SOFT_RESET_CYCLES + 1)-1:0] count_q;
	logic                                     reset_done_q;
	logic                                     request;

	// Falling edge of the request line
	assign request = reset_done_q && !reset_done;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reset_done_q <= 1'b1;
			count_q      <= '0;
		end else begin
			reset_done_q <= reset_done;
			if (request)
				count_q <= SOFT_RESET_CYCLES[$clog2(SOFT_RESET_CYCLES + 1)-1:0];
			else if (count_q != '0)
				count_q <= count_q - 1'b1;
		end
	end

	// Low while counting
	assign soft_rstn = (count_q == '0);

endmodule
